// ==== dcache.f ====
+incdir+common
common/dcache_pkg.sv
common/mem_bus_pkg.sv
dcache/dcache_line_ram.sv
dcache/dcache_ctrl.sv
dcache/dcache_fill_path.sv
dcache/dcache_drain_path.sv
dcache/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_chk.sv
sim/dcache_tb.sv

// ==== Makefile ====
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f dcache.f --top-module dcache_tb -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/Vdcache_tb

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/dcache_tb.sv ====
`default_nettype none

`include "dcache_params.svh"

module dcache_tb;

    localparam int TIMEOUT    = 2000;  // Cycles per CPU access
    localparam int RANDOM_OPS = 300;
    localparam dcache_pkg::word_t LINE_A = 32'h0000_1200;
    localparam dcache_pkg::word_t LINE_B = 32'h0000_3200;  // Same index as LINE_A

    logic clk;
    logic rst;
    logic den;
    dcache_pkg::byte_en_t dwen;
    dcache_pkg::word_t addr, wdata, rdata;
    dcache_pkg::word_t rd_addr, rd_data, wr_addr, wr_data;
    logic data_ok;
    logic rd_req, rd_req_ok, rd_valid, rd_last;
    logic wr_req, wr_req_ok, wr_ready, wr_valid, wr_last, wr_resp_valid;

    dcache_pkg::word_t shadow [dcache_pkg::word_t];
    dcache_pkg::word_t exp_word;
    string             cur_test;
    integer            seed;

    dcache_top u_dut (
        .clk(clk), .rst(rst), .den(den), .dwen(dwen), .addr(addr), .wdata(wdata),
        .rd_req_ok(rd_req_ok), .rd_data(rd_data), .rd_valid(rd_valid),
        .rd_last(rd_last), .wr_req_ok(wr_req_ok), .wr_ready(wr_ready),
        .wr_resp_valid(wr_resp_valid), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_addr(rd_addr), .wr_req(wr_req), .wr_addr(wr_addr),
        .wr_data(wr_data), .wr_valid(wr_valid), .wr_last(wr_last)
    );

    dcache_mem_model u_mem (
        .clk(clk), .rst(rst), .rd_req(rd_req), .rd_addr(rd_addr),
        .rd_req_ok(rd_req_ok), .rd_data(rd_data), .rd_valid(rd_valid),
        .rd_last(rd_last), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .wr_valid(wr_valid), .wr_last(wr_last), .wr_req_ok(wr_req_ok),
        .wr_ready(wr_ready), .wr_resp_valid(wr_resp_valid)
    );

    bind dcache_top dcache_chk u_chk (
        .clk(clk), .rst(rst), .den(den), .data_ok(data_ok), .rd_req(rd_req),
        .rd_req_ok(rd_req_ok), .wr_req(wr_req), .wr_req_ok(wr_req_ok),
        .wr_data(wr_data), .wr_valid(wr_valid), .wr_ready(wr_ready)
    );

    always #4 clk = ~clk;

    // Memory contents before any writeback
    function automatic dcache_pkg::word_t initial_word(dcache_pkg::word_t a);
        return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    // Applies a store to the shadow memory and returns the word a load must see
    function automatic dcache_pkg::word_t ref_access(dcache_pkg::word_t a,
                                                     dcache_pkg::byte_en_t be,
                                                     dcache_pkg::word_t d);
        dcache_pkg::word_t key;
        dcache_pkg::word_t cur;
        key = {a[31:2], 2'b00};
        cur = shadow.exists(key) ? shadow[key] : initial_word(key);
        for (int i = 0; i < `DCACHE_LANES; i++) begin
            if (be[i]) begin
                cur[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        if (be != '0) begin
            shadow[key] = cur;
        end
        return cur;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input dcache_pkg::word_t expected,
                               input dcache_pkg::word_t actual);
        assert (actual == expected)
            else stop_on_error($sformatf("ERROR %s: expected %08h, got %08h",
                                         name, expected, actual));
    endtask

    // One CPU request held until data_ok
    task automatic cpu_access(input string name, input dcache_pkg::word_t a,
                              input dcache_pkg::byte_en_t be, input dcache_pkg::word_t d);
        int waited;
        @(posedge clk);
        cur_test = name;
        exp_word = ref_access(a, be, d);
        den   <= 1'b1;
        addr  <= a;
        dwen  <= be;
        wdata <= d;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error($sformatf("Timeout: %s got no data_ok within %0d cycles",
                                        name, TIMEOUT));
            end
        end while (!data_ok);
        den <= 1'b0;
    endtask

    // Load data checked in the data_ok cycle
    always @(posedge clk) begin
        if (!rst && den && data_ok && dwen == '0) begin
            check_value(cur_test, exp_word, rdata);
        end
    end

    initial begin
        logic [31:0]          r;
        dcache_pkg::word_t    a;
        dcache_pkg::word_t    d;
        dcache_pkg::byte_en_t be;
        int                   bursts;

        clk   = 1'b0;
        rst   = 1'b1;
        den   = 1'b0;
        dwen  = '0;
        addr  = '0;
        wdata = '0;
        seed  = 32'hcb89;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        bursts = u_mem.rd_bursts;
        cpu_access("cold load", LINE_A + 32'h34, 4'b0000, '0);
        check_value("cold load burst count", dcache_pkg::word_t'(bursts + 1),
                    dcache_pkg::word_t'(u_mem.rd_bursts));
        check_value("cold load rd_addr", LINE_A, u_mem.last_rd_addr);

        bursts = u_mem.rd_bursts;
        cpu_access("hit load", LINE_A + 32'h08, 4'b0000, '0);
        check_value("hit load burst count", dcache_pkg::word_t'(bursts),
                    dcache_pkg::word_t'(u_mem.rd_bursts));

        cpu_access("store low half", LINE_A + 32'h04, 4'b0011, 32'hdead_beef);
        cpu_access("store top byte", LINE_A + 32'h04, 4'b1000, 32'h1122_3344);
        cpu_access("merged load", LINE_A + 32'h04, 4'b0000, '0);
        cpu_access("store middle", LINE_A + 32'h3c, 4'b0110, 32'ha5a5_a5a5);
        cpu_access("merged load end", LINE_A + 32'h3c, 4'b0000, '0);

        // Dirty victim goes out while LINE_B comes in
        bursts = u_mem.wr_bursts;
        cpu_access("conflict load", LINE_B + 32'h10, 4'b0000, '0);
        check_value("writeback count", dcache_pkg::word_t'(bursts + 1),
                    dcache_pkg::word_t'(u_mem.wr_bursts));
        check_value("writeback address", LINE_A, u_mem.last_wr_addr);
        check_value("writeback beats", dcache_pkg::word_t'(`DCACHE_WORDS),
                    dcache_pkg::word_t'(u_mem.wr_beats));
        for (int i = 0; i < `DCACHE_WORDS; i++) begin
            check_value($sformatf("writeback word %0d", i),
                        ref_access(LINE_A + dcache_pkg::word_t'(i * 4), 4'b0000, '0),
                        u_mem.wr_line[i]);
        end
        cpu_access("reload stored", LINE_A + 32'h04, 4'b0000, '0);

        // Four tags on two indices
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r  = $random(seed);
            d  = $random(seed);
            a  = {16'h0001, 1'b0, r[1:0], 6'd0, r[2], r[6:3], 2'b00};
            be = r[7] ? r[11:8] : 4'b0000;
            cpu_access($sformatf("random op %0d", i), a, be, d);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/dcache_chk.sv ====
`default_nettype none

module dcache_chk (
    input wire                    clk,
    input wire                    rst,
    input wire                    den,
    input wire                    data_ok,
    input wire                    rd_req,
    input wire                    rd_req_ok,
    input wire                    wr_req,
    input wire                    wr_req_ok,
    input wire dcache_pkg::word_t wr_data,
    input wire                    wr_valid,
    input wire                    wr_ready
);

    rd_req_held: assert property (@(posedge clk) disable iff (rst)
        rd_req && !rd_req_ok |=> rd_req)
        else $error("rd_req dropped before rd_req_ok");

    wr_req_held: assert property (@(posedge clk) disable iff (rst)
        wr_req && !wr_req_ok |=> wr_req)
        else $error("wr_req dropped before wr_req_ok");

    // A stalled beat must not change
    wr_beat_held: assert property (@(posedge clk) disable iff (rst)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_data))
        else $error("wr_data or wr_valid changed while wr_ready was low");

    data_ok_needs_den: assert property (@(posedge clk) disable iff (rst)
        data_ok |-> den)
        else $error("data_ok raised without den");

endmodule

`default_nettype wire

// ==== sim/dcache_mem_model.sv ====
`default_nettype none

`include "dcache_params.svh"

// Burst memory behind the cache with random stalls on every handshake
module dcache_mem_model (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    rd_req,
    input  wire dcache_pkg::word_t rd_addr,
    output logic                   rd_req_ok,
    output dcache_pkg::word_t      rd_data,
    output logic                   rd_valid,
    output logic                   rd_last,
    input  wire                    wr_req,
    input  wire dcache_pkg::word_t wr_addr,
    input  wire dcache_pkg::word_t wr_data,
    input  wire                    wr_valid,
    input  wire                    wr_last,
    output logic                   wr_req_ok,
    output logic                   wr_ready,
    output logic                   wr_resp_valid
);

    dcache_pkg::word_t mem [dcache_pkg::word_t];  // Written words only
    dcache_pkg::word_t wr_line [`DCACHE_WORDS];   // Last burst received
    dcache_pkg::word_t rd_base;
    dcache_pkg::word_t last_rd_addr;
    dcache_pkg::word_t last_wr_addr;
    integer            seed;
    int                rd_bursts;
    int                wr_bursts;
    int                wr_beats;
    int                rd_beat;
    int                wr_beat;
    logic              rd_busy;
    logic [1:0]        wr_phase;  // Request, data, response

    initial begin
        seed          = 32'hcb89;
        rd_req_ok     = 1'b0;
        rd_data       = '0;
        rd_valid      = 1'b0;
        rd_last       = 1'b0;
        wr_req_ok     = 1'b0;
        wr_ready      = 1'b0;
        wr_resp_valid = 1'b0;
        rd_busy       = 1'b0;
        wr_phase      = 2'd0;
        rd_bursts     = 0;
        wr_bursts     = 0;
        wr_beats      = 0;
    end

    function automatic dcache_pkg::word_t initial_word(dcache_pkg::word_t a);
        return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic dcache_pkg::word_t read_word(dcache_pkg::word_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return initial_word(a);
    endfunction

    // Three cycles in four go ahead
    function automatic logic no_stall();
        return ($random(seed) & 32'h3) != 0;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rd_req_ok <= 1'b0;
            rd_valid  <= 1'b0;
            rd_last   <= 1'b0;
            rd_busy   <= 1'b0;
        end else if (!rd_busy) begin
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
            if (rd_req && rd_req_ok) begin
                rd_busy      <= 1'b1;
                rd_base      <= rd_addr;
                rd_beat      <= 0;
                rd_req_ok    <= 1'b0;
                last_rd_addr <= rd_addr;
                rd_bursts    <= rd_bursts + 1;
            end else begin
                rd_req_ok <= no_stall();
            end
        end else if (no_stall()) begin
            rd_valid <= 1'b1;
            rd_data  <= read_word(rd_base + dcache_pkg::word_t'(rd_beat * 4));
            rd_last  <= (rd_beat == `DCACHE_WORDS - 1);
            rd_beat  <= rd_beat + 1;
            rd_busy  <= (rd_beat != `DCACHE_WORDS - 1);
        end else begin
            rd_valid <= 1'b0;  // Gap in the burst
            rd_last  <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wr_req_ok     <= 1'b0;
            wr_ready      <= 1'b0;
            wr_resp_valid <= 1'b0;
            wr_phase      <= 2'd0;
        end else begin
            case (wr_phase)
                2'd0: begin
                    if (wr_req && wr_req_ok) begin
                        wr_phase     <= 2'd1;
                        wr_req_ok    <= 1'b0;
                        wr_ready     <= no_stall();
                        wr_beat      <= 0;
                        wr_beats     <= 0;
                        last_wr_addr <= wr_addr;
                        wr_bursts    <= wr_bursts + 1;
                    end else begin
                        wr_req_ok <= no_stall();
                    end
                end
                2'd1: begin
                    if (wr_valid && wr_ready) begin
                        mem[last_wr_addr + dcache_pkg::word_t'(wr_beat * 4)] = wr_data;
                        wr_line[wr_beat] <= wr_data;
                        wr_beat          <= wr_beat + 1;
                        wr_beats         <= wr_beats + 1;
                        if (wr_last) begin
                            wr_phase <= 2'd2;
                            wr_ready <= 1'b0;
                        end else begin
                            wr_ready <= no_stall();
                        end
                    end else begin
                        wr_ready <= no_stall();
                    end
                end
                2'd2: begin
                    if (wr_resp_valid) begin
                        wr_resp_valid <= 1'b0;
                        wr_phase      <= 2'd0;
                    end else begin
                        wr_resp_valid <= no_stall();
                    end
                end
                default: wr_phase <= 2'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dcache/dcache_top.sv ====
`default_nettype none

`include "dcache_params.svh"

module dcache_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        den,
    input  wire dcache_pkg::byte_en_t  dwen,
    input  wire dcache_pkg::word_t     addr,
    input  wire dcache_pkg::word_t     wdata,
    input  wire                        rd_req_ok,
    input  wire dcache_pkg::word_t     rd_data,
    input  wire                        rd_valid,
    input  wire                        rd_last,
    input  wire                        wr_req_ok,
    input  wire                        wr_ready,
    input  wire                        wr_resp_valid,
    output logic                       data_ok,
    output dcache_pkg::word_t          rdata,
    output logic                       rd_req,
    output dcache_pkg::word_t          rd_addr,
    output logic                       wr_req,
    output dcache_pkg::word_t          wr_addr,
    output dcache_pkg::word_t          wr_data,
    output logic                       wr_valid,
    output logic                       wr_last
);

    localparam int TAG_LSB = `DCACHE_INDEX_W + `DCACHE_OFFSET_W + `DCACHE_BYTE_W;

    dcache_pkg::tag_t    req_tag;
    dcache_pkg::index_t  req_index;
    dcache_pkg::offset_t req_offset;
    dcache_pkg::tag_t    tag_rdata;
    dcache_pkg::word_t   bank_rdata [`DCACHE_WORDS];
    dcache_pkg::word_t   bank_wdata [`DCACHE_WORDS];
    dcache_pkg::word_t   fill_word;
    logic [`DCACHE_WORDS-1:0] bank_we;
    logic capture, line_we, store_we, wb_start, wb_idle;

    assign req_tag    = addr[`DCACHE_ADDR_W-1:TAG_LSB];
    assign req_index  = addr[TAG_LSB-1:`DCACHE_OFFSET_W+`DCACHE_BYTE_W];
    assign req_offset = addr[`DCACHE_OFFSET_W+`DCACHE_BYTE_W-1:`DCACHE_BYTE_W];

    dcache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .den(den), .dwen(dwen), .addr(addr),
        .tag_rdata(tag_rdata), .rd_req_ok(rd_req_ok), .rd_valid(rd_valid),
        .rd_last(rd_last), .wb_idle(wb_idle), .data_ok(data_ok), .rd_req(rd_req),
        .rd_addr(rd_addr), .capture(capture), .line_we(line_we),
        .store_we(store_we), .wb_start(wb_start)
    );

    dcache_line_ram #(.payload_t(dcache_pkg::tag_t)) u_tag_ram (
        .clk(clk), .index(req_index), .we(line_we), .wdata(req_tag), .rdata(tag_rdata)
    );

    for (genvar i = 0; i < `DCACHE_WORDS; i++) begin : g_bank
        dcache_line_ram #(.payload_t(dcache_pkg::word_t)) u_bank (
            .clk(clk), .index(req_index), .we(bank_we[i]),
            .wdata(bank_wdata[i]), .rdata(bank_rdata[i])
        );
    end

    dcache_fill_path u_fill (
        .clk(clk), .rst(rst), .capture(capture), .rd_valid(rd_valid),
        .rd_data(rd_data), .line_we(line_we), .store_we(store_we),
        .offset(req_offset), .dwen(dwen), .wdata(wdata), .bank_rdata(bank_rdata),
        .bank_we(bank_we), .bank_wdata(bank_wdata), .fill_word(fill_word)
    );

    dcache_drain_path u_drain (
        .clk(clk), .rst(rst), .line_we(line_we), .offset(req_offset),
        .fill_word(fill_word), .bank_rdata(bank_rdata), .wb_start(wb_start),
        .victim_tag(tag_rdata), .index(req_index), .wr_req_ok(wr_req_ok),
        .wr_ready(wr_ready), .wr_resp_valid(wr_resp_valid), .rdata(rdata),
        .wb_idle(wb_idle), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .wr_valid(wr_valid), .wr_last(wr_last)
    );

endmodule

`default_nettype wire

// ==== dcache/dcache_drain_path.sv ====
`default_nettype none

`include "dcache_params.svh"

module dcache_drain_path (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        line_we,
    input  wire dcache_pkg::offset_t   offset,
    input  wire dcache_pkg::word_t     fill_word,
    input  wire dcache_pkg::word_t     bank_rdata [`DCACHE_WORDS],
    input  wire                        wb_start,
    input  wire dcache_pkg::tag_t      victim_tag,
    input  wire dcache_pkg::index_t    index,
    input  wire                        wr_req_ok,
    input  wire                        wr_ready,
    input  wire                        wr_resp_valid,
    output dcache_pkg::word_t          rdata,
    output logic                       wb_idle,
    output logic                       wr_req,
    output dcache_pkg::word_t          wr_addr,
    output dcache_pkg::word_t          wr_data,
    output logic                       wr_valid,
    output logic                       wr_last
);

    mem_bus_pkg::wb_state_t state, state_nxt;
    mem_bus_pkg::beat_t     beat;
    dcache_pkg::tag_t       victim_tag_q;
    dcache_pkg::index_t     victim_index_q;

    assign rdata   = line_we ? fill_word : bank_rdata[offset];
    assign wb_idle = (state == mem_bus_pkg::WB_IDLE);
    assign wr_addr = {victim_tag_q, victim_index_q, {(`DCACHE_OFFSET_W + `DCACHE_BYTE_W){1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_bus_pkg::WB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Tag store is overwritten at refill, so keep the victim address
    always_ff @(posedge clk) begin
        if (wb_idle && wb_start) begin
            victim_tag_q   <= victim_tag;
            victim_index_q <= index;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != mem_bus_pkg::WB_WRITE) begin
            beat <= '0;
        end else if (wr_ready) begin
            beat <= beat + mem_bus_pkg::beat_t'(1);
        end
    end

    always_comb begin
        state_nxt = state;
        wr_req    = 1'b0;
        wr_valid  = 1'b0;
        wr_last   = 1'b0;
        wr_data   = bank_rdata[beat];  // Banks hold the victim until refill

        case (state)
            mem_bus_pkg::WB_IDLE: begin
                if (wb_start) state_nxt = mem_bus_pkg::WB_SHAKE;
            end
            mem_bus_pkg::WB_SHAKE: begin
                wr_req = 1'b1;
                if (wr_req_ok) state_nxt = mem_bus_pkg::WB_WRITE;
            end
            mem_bus_pkg::WB_WRITE: begin
                wr_valid = 1'b1;
                wr_last  = &beat;
                if (wr_last && wr_ready) state_nxt = mem_bus_pkg::WB_RESULT;
            end
            mem_bus_pkg::WB_RESULT: begin
                if (wr_resp_valid) state_nxt = mem_bus_pkg::WB_IDLE;
            end
            default: state_nxt = mem_bus_pkg::WB_IDLE;
        endcase
    end

endmodule

`default_nettype wire

// ==== dcache/dcache_fill_path.sv ====
`default_nettype none

`include "dcache_params.svh"

module dcache_fill_path (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        capture,
    input  wire                        rd_valid,
    input  wire dcache_pkg::word_t     rd_data,
    input  wire                        line_we,
    input  wire                        store_we,
    input  wire dcache_pkg::offset_t   offset,
    input  wire dcache_pkg::byte_en_t  dwen,
    input  wire dcache_pkg::word_t     wdata,
    input  wire dcache_pkg::word_t     bank_rdata [`DCACHE_WORDS],
    output logic [`DCACHE_WORDS-1:0]   bank_we,
    output dcache_pkg::word_t          bank_wdata [`DCACHE_WORDS],
    output dcache_pkg::word_t          fill_word
);

    mem_bus_pkg::beat_t beat;
    dcache_pkg::word_t  line_buf [`DCACHE_WORDS];
    dcache_pkg::word_t  byte_mask;

    always_ff @(posedge clk) begin
        if (rst || !capture) begin
            beat <= '0;
        end else if (rd_valid) begin
            beat <= beat + mem_bus_pkg::beat_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (capture && rd_valid) begin
            line_buf[beat] <= rd_data;
        end
    end

    assign fill_word = line_buf[offset];  // Load data in the refill cycle

    always_comb begin
        for (int i = 0; i < `DCACHE_LANES; i++) begin
            byte_mask[i*8 +: 8] = {8{dwen[i]}};
        end
    end

    // Whole line on refill or one merged word on a store hit
    always_comb begin
        for (int i = 0; i < `DCACHE_WORDS; i++) begin
            bank_we[i] = line_we || (store_we && offset == dcache_pkg::offset_t'(i));
            if (line_we) begin
                bank_wdata[i] = line_buf[i];
            end else begin
                bank_wdata[i] = (bank_rdata[i] & ~byte_mask) | (wdata & byte_mask);
            end
        end
    end

endmodule

`default_nettype wire

// ==== dcache/dcache_ctrl.sv ====
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        den,
    input  wire dcache_pkg::byte_en_t  dwen,
    input  wire dcache_pkg::word_t     addr,
    input  wire dcache_pkg::tag_t      tag_rdata,
    input  wire                        rd_req_ok,
    input  wire                        rd_valid,
    input  wire                        rd_last,
    input  wire                        wb_idle,
    output logic                       data_ok,
    output logic                       rd_req,
    output dcache_pkg::word_t          rd_addr,
    output logic                       capture,
    output logic                       line_we,
    output logic                       store_we,
    output logic                       wb_start
);

    localparam int LINE_LSB = `DCACHE_OFFSET_W + `DCACHE_BYTE_W;
    localparam int TAG_LSB  = `DCACHE_INDEX_W + LINE_LSB;

    mem_bus_pkg::ctrl_state_t state, state_nxt;

    logic [2**`DCACHE_INDEX_W-1:0] line_valid;
    logic [2**`DCACHE_INDEX_W-1:0] line_dirty;

    dcache_pkg::tag_t   req_tag;
    dcache_pkg::index_t req_index;
    logic               hit;

    assign req_tag   = addr[`DCACHE_ADDR_W-1:TAG_LSB];
    assign req_index = addr[TAG_LSB-1:LINE_LSB];
    assign hit       = line_valid[req_index] && (tag_rdata == req_tag);

    // Refill always starts at word zero
    assign rd_addr = {addr[`DCACHE_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_bus_pkg::CTRL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
            line_dirty <= '0;
        end else if (line_we) begin
            line_valid[req_index] <= 1'b1;
            line_dirty[req_index] <= 1'b0;  // Fresh copy of memory
        end else if (store_we) begin
            line_dirty[req_index] <= 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        data_ok   = 1'b0;
        rd_req    = 1'b0;
        capture   = 1'b0;
        line_we   = 1'b0;
        store_we  = 1'b0;
        wb_start  = 1'b0;

        case (state)
            mem_bus_pkg::CTRL_IDLE: begin
                if (den && hit) begin
                    data_ok  = 1'b1;
                    store_we = |dwen;
                end else if (den && wb_idle) begin
                    // Victim goes out while the new line comes in
                    rd_req   = 1'b1;
                    wb_start = line_dirty[req_index];
                    state_nxt = rd_req_ok ? mem_bus_pkg::CTRL_RWAIT
                                          : mem_bus_pkg::CTRL_RSHAKE;
                end
            end
            mem_bus_pkg::CTRL_RSHAKE: begin
                rd_req = 1'b1;
                if (rd_req_ok) begin
                    state_nxt = mem_bus_pkg::CTRL_RWAIT;
                end
            end
            mem_bus_pkg::CTRL_RWAIT: begin
                capture = 1'b1;
                if (rd_valid && rd_last) begin
                    state_nxt = wb_idle ? mem_bus_pkg::CTRL_REFILL
                                        : mem_bus_pkg::CTRL_WBWAIT;
                end
            end
            mem_bus_pkg::CTRL_WBWAIT: begin
                if (wb_idle) begin
                    state_nxt = mem_bus_pkg::CTRL_REFILL;
                end
            end
            mem_bus_pkg::CTRL_REFILL: begin
                line_we   = 1'b1;
                data_ok   = den && (dwen == '0);  // Stores retry as a hit
                state_nxt = mem_bus_pkg::CTRL_IDLE;
            end
            default: begin
                state_nxt = mem_bus_pkg::CTRL_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== dcache/dcache_line_ram.sv ====
`default_nettype none

`include "dcache_params.svh"

// One entry per cache line with a read that needs no clock
module dcache_line_ram #(
    parameter type payload_t = dcache_pkg::word_t
) (
    input  wire                    clk,
    input  wire dcache_pkg::index_t index,
    input  wire                    we,
    input  wire payload_t          wdata,
    output payload_t               rdata
);

    payload_t mem [2**`DCACHE_INDEX_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];  // Distributed RAM style

endmodule

`default_nettype wire

// ==== common/mem_bus_pkg.sv ====
`default_nettype none

`include "dcache_params.svh"

package mem_bus_pkg;

    typedef enum logic [2:0] {
        CTRL_IDLE   = 3'd0,
        CTRL_RSHAKE = 3'd1,  // Waiting for rd_req_ok
        CTRL_RWAIT  = 3'd2,  // Receiving refill beats
        CTRL_WBWAIT = 3'd3,
        CTRL_REFILL = 3'd4
    } ctrl_state_t;

    typedef enum logic [1:0] {
        WB_IDLE   = 2'd0,
        WB_SHAKE  = 2'd1,
        WB_WRITE  = 2'd2,
        WB_RESULT = 2'd3   // Waiting for wr_resp_valid
    } wb_state_t;

    typedef logic [`DCACHE_OFFSET_W-1:0] beat_t;

endpackage

`default_nettype wire

// ==== common/dcache_pkg.sv ====
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    // Data word and byte address
    typedef logic [`DCACHE_ADDR_W-1:0] word_t;

    // Upper address bits kept in the tag store
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;

    // Line select
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;

    // Word within a line
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    // One bit per byte lane and all zero for a load
    typedef logic [`DCACHE_LANES-1:0] byte_en_t;

endpackage

`default_nettype wire

// ==== common/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Address and data width
`define DCACHE_ADDR_W 32

// 128 lines of 16 words
`define DCACHE_INDEX_W 7
`define DCACHE_OFFSET_W 4
`define DCACHE_WORDS 16

// Byte lanes per word and the address bits they take
`define DCACHE_LANES 4
`define DCACHE_BYTE_W 2

`define DCACHE_TAG_W (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W - `DCACHE_BYTE_W)

`endif
